// ==== logic/fetchPkg.sv ====
// Shared definitions of the instruction fetch stage
// Address and instruction widths, reset pc
// Memory request and response structs
// Fetch output and redirect structs
// Fetch FSM states
package fetchPkg;

    localparam int addrWidth = 32;
    localparam int insnWidth = 32;
    localparam int insnSize = 4;
    localparam logic [addrWidth-1:0] initialPc = 32'h0000_0000;

    // Memory side always moves whole 128-bit lines
    localparam int memLineWidth = 128;
    localparam int memOffsetWidth = $clog2(memLineWidth / 8);

    typedef struct packed {
        logic readEnable;
        logic [addrWidth-memOffsetWidth-1:0] lineAddr;
    } memReq;

    typedef struct packed {
        logic grant;
        logic [memLineWidth-1:0] line;
    } memResp;

    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] pc;
        logic [insnWidth-1:0] insn;
    } fetchOut;

    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] target;
    } redirect;

    typedef enum logic [1:0] {
        stateFetch = 2'h0,
        stateInvalidate = 2'h1,
        stateRefill = 2'h2
    } fetchState;

endpackage

// ==== logic/lineRam.sv ====
`timescale 1ns/100ps
// Single-port block RAM
// One registered read and one write per cycle, write-first
module lineRam #(
    parameter int dataWidth = 32,
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic [indexWidth-1:0] index,
    input  logic                  writeEnable,
    input  logic [dataWidth-1:0]  writeValue,
    output logic [dataWidth-1:0]  readValue
);

    logic [dataWidth-1:0] mem [2**indexWidth];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[index] <= writeValue;
            // New data visible on the read port in the same cycle
            readValue <= writeValue;
        end else begin
            readValue <= mem[index];
        end
    end

endmodule

// ==== logic/cacheInvalidater.sv ====
`timescale 1ns/100ps
// Whole-cache invalidation
// Latches requests, walks every index and clears its valid bit
module cacheInvalidater #(
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  invalidate,
    input  logic                  enable,
    output logic                  arrayWriteEnable,
    output logic [indexWidth-1:0] arrayIndex,
    output logic                  waitInvalidate,
    output logic                  done
);

    logic pending;
    logic restart;
    logic lastIndex;
    logic [indexWidth-1:0] walkIndex;

    always_comb begin
        lastIndex = (walkIndex == '1);
        arrayWriteEnable = enable;
        arrayIndex = walkIndex;
        waitInvalidate = pending;
        done = enable && lastIndex;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Cache contents are unknown after reset
            pending <= 1'b1;
            restart <= 1'b0;
            walkIndex <= '0;
        end else begin
            if (enable) begin
                walkIndex <= walkIndex + 1'b1;
            end
            if (enable && lastIndex) begin
                pending <= restart || invalidate;
                restart <= 1'b0;
            end else begin
                if (invalidate) begin
                    pending <= 1'b1;
                end
                // Request in the middle of a walk needs a second walk
                if (invalidate && enable) begin
                    restart <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/lineReplacer.sv ====
`timescale 1ns/100ps
// Cache line refill
// Requests the missing line from memory and writes
// its data, tag and valid bit into the arrays on the grant
module lineReplacer
    import fetchPkg::*;
#(
    parameter int lineWords = 4,
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic [addrWidth-$clog2(lineWords*insnSize)-1:0] missAddr,
    output fetchPkg::memReq       memReq,
    input  fetchPkg::memResp      memResp,
    output logic                  arrayWriteEnable,
    output logic [indexWidth-1:0] arrayIndex,
    output logic [addrWidth-$clog2(lineWords*insnSize)-indexWidth-1:0] arrayWriteTag,
    output logic [lineWords*insnWidth-1:0] arrayWriteLine,
    output logic                  done
);

    localparam int offsetWidth = $clog2(lineWords * insnSize);
    localparam int lineAddrWidth = addrWidth - offsetWidth;

    logic requesting;
    logic finishing;
    logic start;
    logic [lineAddrWidth-1:0] lineAddr;

    always_comb begin
        start = enable && !requesting && !finishing;

        memReq.readEnable = requesting;
        memReq.lineAddr = lineAddr;

        // Line goes straight from the bus into the arrays
        arrayWriteEnable = requesting && memResp.grant;
        arrayIndex = lineAddr[indexWidth-1:0];
        arrayWriteTag = lineAddr[lineAddrWidth-1:indexWidth];
        arrayWriteLine = memResp.line;

        done = finishing;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            requesting <= 1'b0;
            finishing <= 1'b0;
        end else begin
            if (start) begin
                requesting <= 1'b1;
            end else if (requesting && memResp.grant) begin
                requesting <= 1'b0;
            end
            finishing <= requesting && memResp.grant;
        end
    end

    // Pc may be redirected while the refill is running
    always_ff @(posedge clk) begin
        if (start) begin
            lineAddr <= missAddr;
        end
    end

endmodule

// ==== logic/redirectControl.sv ====
`timescale 1ns/100ps
// Redirect selection for the fetch stage
// Trap wins over flush; two-cycle hold after every flush
module redirectControl
    import fetchPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic [addrWidth-1:0] flushPc,
    input  logic                 trap,
    input  logic [addrWidth-1:0] trapPc,
    output fetchPkg::redirect    redirect,
    output logic                 hold
);

    localparam int holdCycles = 2;
    localparam int countWidth = $clog2(holdCycles + 1);

    logic [countWidth-1:0] holdCount;

    always_comb begin
        redirect.valid = trap || flush;
        redirect.target = trap ? trapPc : flushPc;
        hold = (holdCount != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            holdCount <= '0;
        end else if (flush) begin
            holdCount <= countWidth'(holdCycles);
        end else if (hold) begin
            holdCount <= holdCount - 1'b1;
        end
    end

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/100ps
// Fetch unit core
// Program counter and fetch FSM
// Tag and data arrays with their port multiplexing
// Hit detection and instruction word select
module fetchUnit
    import fetchPkg::*;
#(
    parameter int lineWords = 4,
    parameter int indexWidth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  fetchPkg::redirect redirect,
    input  logic              stall,
    input  logic              hold,
    input  logic              invalidate,
    output fetchPkg::memReq   memReq,
    input  fetchPkg::memResp  memResp,
    output fetchPkg::fetchOut fetchOut
);

    localparam int lineWidth = lineWords * insnWidth;
    localparam int wordSelWidth = $clog2(lineWords);
    localparam int offsetWidth = $clog2(lineWords * insnSize);
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth;

    typedef struct packed {
        logic valid;
        logic [tagWidth-1:0] tag;
    } tagEntry;

    fetchState state;
    fetchState nextState;
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] nextPc;
    logic readFlag;
    logic nextRead;

    logic stalled;
    logic hit;
    logic miss;
    logic [wordSelWidth-1:0] wordSel;

    tagEntry tagRead;
    tagEntry tagWrite;
    logic [indexWidth-1:0] tagIndex;
    logic tagWriteEnable;

    logic [lineWidth-1:0] dataRead;
    logic [indexWidth-1:0] dataIndex;
    logic dataWriteEnable;

    logic invEnable;
    logic invWriteEnable;
    logic [indexWidth-1:0] invIndex;
    logic waitInvalidate;
    logic invDone;

    logic repEnable;
    logic repWriteEnable;
    logic [indexWidth-1:0] repIndex;
    logic [tagWidth-1:0] repTag;
    logic [lineWidth-1:0] repLine;
    logic repDone;

    lineRam #(
        .dataWidth($bits(tagEntry)),
        .indexWidth(indexWidth)
    ) tagArray (
        .clk(clk),
        .index(tagIndex),
        .writeEnable(tagWriteEnable),
        .writeValue(tagWrite),
        .readValue(tagRead)
    );

    lineRam #(
        .dataWidth(lineWidth),
        .indexWidth(indexWidth)
    ) dataArray (
        .clk(clk),
        .index(dataIndex),
        .writeEnable(dataWriteEnable),
        .writeValue(repLine),
        .readValue(dataRead)
    );

    cacheInvalidater #(
        .indexWidth(indexWidth)
    ) invalidater (
        .clk(clk),
        .rst(rst),
        .invalidate(invalidate),
        .enable(invEnable),
        .arrayWriteEnable(invWriteEnable),
        .arrayIndex(invIndex),
        .waitInvalidate(waitInvalidate),
        .done(invDone)
    );

    lineReplacer #(
        .lineWords(lineWords),
        .indexWidth(indexWidth)
    ) replacer (
        .clk(clk),
        .rst(rst),
        .enable(repEnable),
        .missAddr(pc[addrWidth-1:offsetWidth]),
        .memReq(memReq),
        .memResp(memResp),
        .arrayWriteEnable(repWriteEnable),
        .arrayIndex(repIndex),
        .arrayWriteTag(repTag),
        .arrayWriteLine(repLine),
        .done(repDone)
    );

    always_comb begin
        stalled = stall || hold;
        hit = readFlag && tagRead.valid && (tagRead.tag == pc[addrWidth-1 -: tagWidth]);
        miss = readFlag && !hit;
        wordSel = pc[offsetWidth-1 -: wordSelWidth];

        fetchOut.valid = hit;
        fetchOut.pc = pc;
        fetchOut.insn = dataRead[wordSel*insnWidth +: insnWidth];
    end

    always_comb begin
        if (redirect.valid) begin
            nextPc = redirect.target;
        end else if (hit && !stalled) begin
            nextPc = pc + insnSize;
        end else begin
            nextPc = pc;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stateInvalidate: begin
                if (invDone) begin
                    nextState = stateFetch;
                end
            end
            stateRefill: begin
                if (repDone) begin
                    nextState = waitInvalidate ? stateInvalidate : stateFetch;
                end
            end
            default: begin
                if (waitInvalidate) begin
                    nextState = stateInvalidate;
                end else if (miss && !redirect.valid) begin
                    // Redirected pc gets its own lookup first
                    nextState = stateRefill;
                end
            end
        endcase

        nextRead = (state == stateFetch) && (nextState == stateFetch) &&
            !stalled && !redirect.valid;

        invEnable = (state == stateInvalidate);
        repEnable = (state == stateRefill);
    end

    // Array ports belong to the lookup unless a walk or a refill owns them
    always_comb begin
        tagIndex = nextPc[offsetWidth +: indexWidth];
        tagWrite = '0;
        tagWriteEnable = 1'b0;
        dataIndex = nextPc[offsetWidth +: indexWidth];
        dataWriteEnable = 1'b0;
        case (state)
            stateInvalidate: begin
                tagIndex = invIndex;
                tagWriteEnable = invWriteEnable;
            end
            stateRefill: begin
                tagIndex = repIndex;
                tagWrite.valid = 1'b1;
                tagWrite.tag = repTag;
                tagWriteEnable = repWriteEnable;
                dataIndex = repIndex;
                dataWriteEnable = repWriteEnable;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateFetch;
            pc <= initialPc;
            readFlag <= 1'b0;
        end else begin
            state <= nextState;
            pc <= nextPc;
            readFlag <= nextRead;
        end
    end

endmodule

// ==== logic/fetchTop.sv ====
`timescale 1ns/100ps
// Instruction fetch stage top level
// Redirect control and fetch unit
module fetchTop
    import fetchPkg::*;
#(
    parameter int lineWords = 4,
    parameter int indexWidth = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic [addrWidth-1:0] flushPc,
    input  logic                 trap,
    input  logic [addrWidth-1:0] trapPc,
    input  logic                 stall,
    input  logic                 invalidate,
    input  fetchPkg::memResp     memResp,
    output fetchPkg::memReq      memReq,
    output fetchPkg::fetchOut    fetchOut
);

    fetchPkg::redirect fetchRedirect;
    logic hold;

    redirectControl redirectCtrl (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .flushPc(flushPc),
        .trap(trap),
        .trapPc(trapPc),
        .redirect(fetchRedirect),
        .hold(hold)
    );

    fetchUnit #(
        .lineWords(lineWords),
        .indexWidth(indexWidth)
    ) fetch (
        .clk(clk),
        .rst(rst),
        .redirect(fetchRedirect),
        .stall(stall),
        .hold(hold),
        .invalidate(invalidate),
        .memReq(memReq),
        .memResp(memResp),
        .fetchOut(fetchOut)
    );

endmodule

// ==== dv/fetchUnit_assert.sv ====
`timescale 1ns/100ps
// Concurrent assertions for the fetch unit
// Memory read held until its grant, no output during a refill,
// quiet outputs after reset
module fetchUnitAssert
    import fetchPkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                hold,
    input fetchPkg::fetchState state,
    input fetchPkg::memReq     memReq,
    input fetchPkg::memResp    memResp,
    input fetchPkg::fetchOut   fetchOut
);

    readHeldUntilGrant: assert property (
        @(posedge clk) disable iff (rst)
        memReq.readEnable && !memResp.grant |=> memReq.readEnable
    ) else $error("memory read dropped before its grant arrived");

    noOutputInRefill: assert property (
        @(posedge clk) disable iff (rst)
        state == stateRefill |-> !fetchOut.valid
    ) else $error("fetch output valid while a refill is running");

    quietAfterReset: assert property (
        @(posedge clk)
        $past(rst) |-> !fetchOut.valid && !memReq.readEnable && !hold
    ) else $error("fetch output, memory read or hold active during reset");

endmodule

bind fetchUnit fetchUnitAssert u_assert (
    .clk(clk),
    .rst(rst),
    .hold(hold),
    .state(state),
    .memReq(memReq),
    .memResp(memResp),
    .fetchOut(fetchOut)
);

// ==== dv/fetchChecker.sv ====
`timescale 1ns/100ps
// Fetch stage checker
// Pc sequence and redirect model, instruction data check,
// flush hold window and cache refill bookkeeping
module fetchChecker
    import fetchPkg::*;
#(
    parameter int lineWords = 4,
    parameter int indexWidth = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic [addrWidth-1:0] flushPc,
    input  logic                 trap,
    input  logic [addrWidth-1:0] trapPc,
    input  logic                 stall,
    input  logic                 invalidate,
    input  fetchPkg::memReq      memReq,
    input  fetchPkg::memResp     memResp,
    input  fetchPkg::fetchOut    fetchOut,
    output int                   validCount,
    output int                   mismatchCount,
    output int                   failureCount
);

    localparam int offsetWidth = $clog2(lineWords * insnSize);

    logic [addrWidth-1:0] expPc;
    logic afterRedirect;
    int holdLeft;
    int cycle;
    int requestStart;
    int lastInvalidate;
    logic prevReadEnable;
    logic clearRefilled;
    // Lines known to sit in the cache, by index
    logic [addrWidth-1:0] presentLine [2**indexWidth];
    logic presentValid [2**indexWidth];
    bit refilled [logic [addrWidth-1:0]];

    task automatic flagMismatch(
        input string testName,
        input logic [addrWidth-1:0] expected,
        input logic [addrWidth-1:0] actual
    );
        $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
        mismatchCount++;
    endtask

    task automatic noteFailure(input string what);
        $display("error at cycle %0d: %s", cycle, what);
        failureCount++;
    endtask

    task automatic checkFetch();
        logic [addrWidth-1:0] line;
        line = expPc >> offsetWidth;
        if (fetchOut.valid) begin
            validCount++;
            if (holdLeft > 0) begin
                noteFailure("fetch output valid within two cycles after a flush");
            end
            if (fetchOut.pc !== expPc) begin
                flagMismatch(afterRedirect ? "redirectTarget" : "pcSequence",
                    expPc, fetchOut.pc);
            end
            if (fetchOut.insn !== ~expPc) begin
                flagMismatch("insnData", ~expPc, fetchOut.insn);
            end
            if (!refilled.exists(line)) begin
                noteFailure($sformatf("pc %h served without a memory read since invalidate",
                    fetchOut.pc));
            end
            afterRedirect = 1'b0;
        end
    endtask

    task automatic trackMemory();
        logic [addrWidth-1:0] line;
        logic [indexWidth-1:0] idx;
        line = addrWidth'(memReq.lineAddr);
        idx = line[indexWidth-1:0];
        if (memReq.readEnable && !prevReadEnable) begin
            requestStart = cycle;
        end
        if (memReq.readEnable && memResp.grant) begin
            if (presentValid[idx] && presentLine[idx] == line) begin
                noteFailure($sformatf("line %h read again while still cached", line));
            end
            // Invalidate close to the miss means a walk may still clear it
            presentLine[idx] = line;
            presentValid[idx] = (lastInvalidate < requestStart - 2);
            refilled[line] = 1'b1;
        end
        prevReadEnable = memReq.readEnable;
    endtask

    task automatic trackInvalidate();
        // Lookup issued in the pulse cycle still sees the old contents
        if (clearRefilled) begin
            refilled.delete();
        end
        clearRefilled = invalidate;
        if (invalidate) begin
            lastInvalidate = cycle;
            for (int i = 0; i < 2**indexWidth; i++) begin
                presentValid[i] = 1'b0;
            end
        end
    endtask

    task automatic advanceModel();
        if (trap || flush) begin
            expPc = trap ? trapPc : flushPc;
            afterRedirect = 1'b1;
        end else if (fetchOut.valid && !stall && holdLeft == 0) begin
            expPc = expPc + insnSize;
        end
        if (flush) begin
            holdLeft = 2;
        end else if (holdLeft > 0) begin
            holdLeft--;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            expPc = initialPc;
            afterRedirect = 1'b0;
            holdLeft = 0;
            cycle = 0;
            requestStart = 0;
            lastInvalidate = -16;
            prevReadEnable = 1'b0;
            clearRefilled = 1'b0;
            validCount = 0;
            mismatchCount = 0;
            failureCount = 0;
            refilled.delete();
            for (int i = 0; i < 2**indexWidth; i++) begin
                presentValid[i] = 1'b0;
            end
        end else begin
            cycle++;
            checkFetch();
            trackMemory();
            trackInvalidate();
            advanceModel();
        end
    end

endmodule

// ==== dv/fetchTb.sv ====
`timescale 1ns/100ps
// Fetch stage testbench
// Clock, reset and LFSR driven random stimulus
// Memory model with random grant latency
// Watchdog and final report
module fetchTb
    import fetchPkg::*;
();

    localparam int lineWords = 4;
    localparam int indexWidth = 4;
    localparam int testLength = 500;
    // Cycles allowed per fetch with misses, flushes and walks
    localparam int latencyMargin = 8;
    localparam logic [addrWidth-1:0] windowBase = 32'h0000_1000;

    logic clk;
    logic rst;
    logic flush;
    logic [addrWidth-1:0] flushPc;
    logic trap;
    logic [addrWidth-1:0] trapPc;
    logic stall;
    logic invalidate;
    fetchPkg::memResp respBus;
    fetchPkg::memReq reqBus;
    fetchPkg::fetchOut fetchResult;

    logic [15:0] lfsrState;
    int stallLeft;
    int memDelay;
    logic memBusy;
    int totalGrants;
    int grantsPerLine [logic [addrWidth-1:0]];
    int validCount;
    int mismatchCount;
    int failureCount;

    fetchTop #(
        .lineWords(lineWords),
        .indexWidth(indexWidth)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .flushPc(flushPc),
        .trap(trap),
        .trapPc(trapPc),
        .stall(stall),
        .invalidate(invalidate),
        .memResp(respBus),
        .memReq(reqBus),
        .fetchOut(fetchResult)
    );

    fetchChecker #(
        .lineWords(lineWords),
        .indexWidth(indexWidth)
    ) u_checker (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .flushPc(flushPc),
        .trap(trap),
        .trapPc(trapPc),
        .stall(stall),
        .invalidate(invalidate),
        .memReq(reqBus),
        .memResp(respBus),
        .fetchOut(fetchResult),
        .validCount(validCount),
        .mismatchCount(mismatchCount),
        .failureCount(failureCount)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Each word of a line holds the inverse of its byte address
    task automatic driveMemory();
        logic [addrWidth-1:0] wordAddr;
        respBus.grant = 1'b0;
        if (reqBus.readEnable && !memBusy) begin
            memBusy = 1'b1;
            memDelay = 1 + int'(randomBits(3) % 6);
        end else if (memBusy) begin
            memDelay--;
            if (memDelay == 0) begin
                memBusy = 1'b0;
                respBus.grant = 1'b1;
                for (int w = 0; w < lineWords; w++) begin
                    wordAddr = {reqBus.lineAddr, {memOffsetWidth{1'b0}}} +
                        addrWidth'(w * insnSize);
                    respBus.line[w*insnWidth +: insnWidth] = ~wordAddr;
                end
                grantsPerLine[addrWidth'(reqBus.lineAddr)]++;
                totalGrants++;
            end
        end
    endtask

    task automatic driveControls();
        if (stallLeft > 0) begin
            stall = 1'b1;
            stallLeft--;
        end else if (randomBits(3) == 0) begin
            stall = 1'b1;
            stallLeft = int'(randomBits(2));
        end else begin
            stall = 1'b0;
        end
        flush = (randomBits(5) == 0);
        flushPc = windowBase + (randomBits(6) << 2);
        // Traps often land together with a flush
        trap = flush ? (randomBits(2) == 0) : (randomBits(6) == 0);
        trapPc = windowBase + (randomBits(6) << 2);
        invalidate = (randomBits(7) == 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        lfsrState = 16'd55;
        rst = 1'b1;
        flush = 1'b0;
        flushPc = '0;
        trap = 1'b0;
        trapPc = '0;
        stall = 1'b0;
        invalidate = 1'b0;
        respBus = '0;
        stallLeft = 0;
        memDelay = 0;
        memBusy = 1'b0;
        totalGrants = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        while (validCount < testLength) begin
            @(posedge clk);
            #1;
            driveMemory();
            driveControls();
        end
        $display("fetches %0d, memory reads %0d over %0d lines, mismatches %0d, errors %0d",
            validCount, totalGrants, grantsPerLine.num(), mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (testLength * latencyMargin) @(posedge clk);
        $display("timeout: only %0d of %0d fetches after %0d cycles",
            validCount, testLength, testLength * latencyMargin);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
logic/fetchPkg.sv
logic/lineRam.sv
logic/cacheInvalidater.sv
logic/lineReplacer.sv
logic/redirectControl.sv
logic/fetchUnit.sv
logic/fetchTop.sv
dv/fetchUnit_assert.sv
dv/fetchChecker.sv
dv/fetchTb.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

SOURCES := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/VfetchTb
	./obj_dir/VfetchTb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "SOME TESTS FAILED" sim.log

obj_dir/VfetchTb: files.f $(SOURCES)
	verilator --binary --assert --top-module fetchTb -f files.f -o VfetchTb

clean:
	rm -rf obj_dir sim.log
